// ==== design/mdu_pkg.sv ====
// Shared definitions for the RV64M multiply unit
// Holds the datapath width, the operation encoding and the
// helpers that tell which operands an operation treats as signed
package mdu_pkg;

    // RV64 register width, the product is twice this
    localparam int XLEN = 64;

    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,  // Low word of signed x signed
        OP_MULH   = 3'd1,  // High word of signed x signed
        OP_MULHSU = 3'd2,  // High word of signed x unsigned
        OP_MULHU  = 3'd3,  // High word of unsigned x unsigned
        OP_MULW   = 3'd4   // Low 32 bits, sign-extended
    } mul_op_t;

    // First operand is signed for MUL, MULH and MULHSU
    function automatic logic op_signed_a(input mul_op_t op);
        return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU);
    endfunction

    // Second operand is signed only for MUL and MULH
    // MULW counts as unsigned since its low 32 product bits do not depend on sign
    function automatic logic op_signed_b(input mul_op_t op);
        return (op == OP_MUL) || (op == OP_MULH);
    endfunction

endpackage

// ==== design/mul_req_if.sv ====
// Request channel from operand preparation into the shift-add core
// Carries the start strobe, the two operand magnitudes, the sign of
// the final product and the operation tag
interface mul_req_if import mdu_pkg::*; ();

    logic            start;   // One cycle, only for an accepted request
    logic [XLEN-1:0] mcand;   // Multiplicand magnitude
    logic [XLEN-1:0] mplier;  // Multiplier magnitude
    logic            negate;  // Product must be negated at the end
    mul_op_t         op;

    modport src (
        output start,
        output mcand,
        output mplier,
        output negate,
        output op
    );

    modport dst (
        input start,
        input mcand,
        input mplier,
        input negate,
        input op
    );

endinterface

// ==== design/mul_rsp_if.sv ====
// Response channel from the shift-add core to result formatting
// Carries the completion strobe, the full unsigned product and
// the tags captured when the request was accepted
interface mul_rsp_if import mdu_pkg::*; ();

    logic              done;     // One cycle when the product is final
    logic [2*XLEN-1:0] product;  // Unsigned product of the magnitudes
    logic              negate;
    mul_op_t           op;

    modport src (
        output done,
        output product,
        output negate,
        output op
    );

    modport dst (
        input done,
        input product,
        input negate,
        input op
    );

endinterface

// ==== design/mul_operand_prep.sv ====
// Operand preparation for the multiply unit
// Decodes the operation, turns signed negative operands into magnitudes,
// works out the sign of the product and starts the core when it is idle
module mul_operand_prep import mdu_pkg::*; (
    input  logic            req_valid,
    input  mul_op_t         req_op,
    input  logic [XLEN-1:0] req_a,
    input  logic [XLEN-1:0] req_b,
    input  logic            busy,
    mul_req_if.src          req
);

    logic [XLEN-1:0] opnd_a;
    logic [XLEN-1:0] opnd_b;
    logic            sign_a;
    logic            sign_b;
    logic            is_word;

    // Two's complement magnitude of a negative value
    // The most negative input comes back unchanged, which is 2^63 as unsigned
    function automatic logic [XLEN-1:0] magnitude(input logic [XLEN-1:0] value);
        return ~value + 1'b1;
    endfunction

    assign is_word = (req_op == OP_MULW);

    // MULW only looks at the low word of each source
    always_comb begin
        if (is_word) begin
            opnd_a = {{(XLEN/2){1'b0}}, req_a[XLEN/2-1:0]};
            opnd_b = {{(XLEN/2){1'b0}}, req_b[XLEN/2-1:0]};
        end else begin
            opnd_a = req_a;
            opnd_b = req_b;
        end
    end

    // An operand is negative only if the operation reads it as signed
    assign sign_a = op_signed_a(req_op) && opnd_a[XLEN-1];
    assign sign_b = op_signed_b(req_op) && opnd_b[XLEN-1];

    assign req.mcand  = sign_a ? magnitude(opnd_a) : opnd_a;
    assign req.mplier = sign_b ? magnitude(opnd_b) : opnd_b;
    assign req.negate = sign_a ^ sign_b;
    assign req.op     = req_op;

    // A request arriving while the core works is simply not taken
    assign req.start = req_valid && !busy;

endmodule

// ==== design/mul_shift_add.sv ====
// Iterative shift-and-add multiplier core
// Each cycle the multiplicand moves left, the multiplier moves right and
// the multiplicand is added in when the multiplier LSB is set
// The loop stops as soon as no multiplier bits remain
module mul_shift_add import mdu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    mul_req_if.dst  req,
    mul_rsp_if.src  rsp,
    output logic    busy
);

    logic [2*XLEN-1:0] mcand_q;   // Multiplicand, shifted left each step
    logic [XLEN-1:0]   mplier_q;  // Remaining multiplier bits
    logic [2*XLEN-1:0] acc_q;     // Running sum of partial products
    logic              negate_q;
    mul_op_t           op_q;
    logic              busy_q;
    logic              done_q;

    logic [2*XLEN-1:0] addend;
    logic              last;

    // Partial product for this step
    assign addend = mplier_q[0] ? mcand_q : '0;

    // Nothing left to add, so the accumulator holds the final product
    assign last = busy_q && (mplier_q == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= last;
            if (req.start) begin
                busy_q <= 1'b1;
            end else if (last) begin
                busy_q <= 1'b0;  // Falls together with the rise of done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            mcand_q  <= {{XLEN{1'b0}}, req.mcand};
            mplier_q <= req.mplier;
            acc_q    <= '0;
            negate_q <= req.negate;
            op_q     <= req.op;
        end else if (busy_q && !last) begin
            acc_q    <= acc_q + addend;
            mcand_q  <= {mcand_q[2*XLEN-2:0], 1'b0};
            mplier_q <= {1'b0, mplier_q[XLEN-1:1]};
        end
    end

    assign busy = busy_q;

    // The accumulator stays put after done until the next start,
    // which can only land on the edge where the formatter samples it
    assign rsp.done    = done_q;
    assign rsp.product = acc_q;
    assign rsp.negate  = negate_q;
    assign rsp.op      = op_q;

endmodule

// ==== design/mul_result_format.sv ====
// Result formatting for the multiply unit
// Restores the sign of the 128-bit product, picks the low word, the high
// word or the sign-extended low 32 bits, and registers it with res_valid
module mul_result_format import mdu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    mul_rsp_if.dst          rsp,
    output logic            res_valid,
    output logic [XLEN-1:0] res_data
);

    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   selected;

    // Whole product is negated so the high word gets the borrow from the low word
    assign product = rsp.negate ? (~rsp.product + 1'b1) : rsp.product;

    always_comb begin
        case (rsp.op)
            OP_MUL: begin
                selected = product[XLEN-1:0];
            end
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                selected = product[2*XLEN-1:XLEN];
            end
            OP_MULW: begin
                // Word result is the low half of XLEN, extended from its top bit
                selected = {{(XLEN/2){product[XLEN/2-1]}}, product[XLEN/2-1:0]};
            end
            default: begin
                selected = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_data  <= '0;
        end else begin
            res_valid <= rsp.done;  // Single cycle, follows done by one
            if (rsp.done) begin
                res_data <= selected;
            end
        end
    end

endmodule

// ==== design/mdu_top.sv ====
// RV64M multiply unit top level
// Accepts a request while idle, runs it through operand preparation,
// the shift-add core and result formatting, and pulses res_valid at the end
module mdu_top import mdu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            req_valid,
    input  mul_op_t         req_op,
    input  logic [XLEN-1:0] req_a,
    input  logic [XLEN-1:0] req_b,
    output logic            busy,
    output logic            res_valid,
    output logic [XLEN-1:0] res_data
);

    mul_req_if req_ch ();
    mul_rsp_if rsp_ch ();

    // busy goes back to prep so that only one request enters the core
    mul_operand_prep u_prep (
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_a     (req_a),
        .req_b     (req_b),
        .busy      (busy),
        .req       (req_ch.src)
    );

    mul_shift_add u_core (
        .clk   (clk),
        .reset (reset),
        .req   (req_ch.dst),
        .rsp   (rsp_ch.src),
        .busy  (busy)
    );

    mul_result_format u_format (
        .clk       (clk),
        .reset     (reset),
        .rsp       (rsp_ch.dst),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

// ==== verif/mdu_chk.sv ====
// Handshake checks for the multiply unit top level
// Bound to mdu_top and watches busy and res_valid at its ports
module mdu_chk (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic res_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // A result is only ever a single-cycle pulse
    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        res_valid |=> !res_valid
    ) else $error("res_valid was high on two consecutive cycles");

    // The core goes idle in the cycle before the result appears.
    // busy may rise again together with res_valid when the next request is taken
    a_idle_before_result: assert property (
        @(posedge clk) disable iff (reset)
        res_valid |-> !$past(busy)
    ) else $error("busy was high in the cycle before res_valid");

    a_reset_clears: assert property (
        @(posedge clk)
        reset |=> (!busy && !res_valid)  // Synchronous reset clears both flags
    ) else $error("busy or res_valid set in the cycle after reset");

endmodule

bind mdu_top mdu_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .res_valid (res_valid)
);

// ==== verif/mdu_tb.sv ====
// Testbench for the RV64M multiply unit
// Drives requests through mdu_top, predicts each result from the RV64M
// rules and compares every res_valid pulse against the predictions in order
module mdu_tb import mdu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Upper bound on requests over all tests, used for the cycle limit
    localparam int MAX_REQUESTS = 125 + 18 + 6 + 200 + 40 + 5;
    localparam int CYCLE_LIMIT  = MAX_REQUESTS * 70 + 100;

    logic            clk;
    logic            reset;
    logic            req_valid;
    mul_op_t         req_op;
    logic [XLEN-1:0] req_a;
    logic [XLEN-1:0] req_b;
    logic            busy;
    logic            res_valid;
    logic [XLEN-1:0] res_data;

    logic [XLEN-1:0] exp_q[$];  // Expected results in issue order
    mul_op_t         op_q[$];
    integer          seed;
    int              pass_count = 0;
    int              fail_count = 0;
    int              res_count = 0;
    int              accepted = 0;
    int              cycles = 0;
    int              test_pass_mark;
    int              test_fail_mark;

    mdu_top DUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_a     (req_a),
        .req_b     (req_b),
        .busy      (busy),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected result straight from the RV64M definitions
    function automatic logic [XLEN-1:0] ref_mul(input mul_op_t op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic              sa;
        logic              sb;
        logic [2*XLEN-1:0] ea;
        logic [2*XLEN-1:0] eb;
        logic [2*XLEN-1:0] prod;
        case (op)
            OP_MUL, OP_MULH: begin
                sa = 1'b1;
                sb = 1'b1;
            end
            OP_MULHSU: begin
                sa = 1'b1;
                sb = 1'b0;
            end
            default: begin
                sa = 1'b0;
                sb = 1'b0;
            end
        endcase
        ea = sa ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        eb = sb ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod = ea * eb;  // Modulo 2^128 product of the extended operands
        case (op)
            OP_MUL:  return prod[XLEN-1:0];
            OP_MULW: return {{(XLEN/2){prod[XLEN/2-1]}}, prod[XLEN/2-1:0]};
            default: return prod[2*XLEN-1:XLEN];
        endcase
    endfunction

    function automatic mul_op_t op_from_index(input int idx);
        case (idx)
            0:       return OP_MUL;
            1:       return OP_MULH;
            2:       return OP_MULHSU;
            3:       return OP_MULHU;
            default: return OP_MULW;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] corner_value(input int idx);
        case (idx)
            0:       return '0;
            1:       return 64'd1;
            2:       return '1;
            3:       return {1'b1, {(XLEN-1){1'b0}}};
            default: return {1'b0, {(XLEN-1){1'b1}}};
        endcase
    endfunction

    function logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function int rand_op_index();
        return $unsigned($random(seed)) % 5;
    endfunction

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input mul_op_t op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        while (busy) @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        exp_q.push_back(ref_mul(op, a, b));
        op_q.push_back(op);
        accepted++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (busy || exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic begin_test();
        test_pass_mark = pass_count;
        test_fail_mark = fail_count;
    endtask

    task automatic end_test(input string name);
        drain();
        $display("%s: %0d checks passed, %0d failed", name, pass_count - test_pass_mark,
                 fail_count - test_fail_mark);
    endtask

    always @(negedge clk) begin : compare_results
        logic [XLEN-1:0] expected;
        mul_op_t         op;
        if (!reset && res_valid) begin
            res_count++;
            if (exp_q.size() == 0) begin
                $display("Result 0x%h at %0t ns arrived with no request outstanding",
                         res_data, $time);
                fail_count++;
            end else begin
                expected = exp_q.pop_front();
                op = op_q.pop_front();
                if (res_data !== expected) begin
                    $display("[FAIL] %0t ns: %s result 0x%h, expected 0x%h", $time, op.name(),
                             res_data, expected);
                    fail_count++;
                end else begin
                    pass_count++;
                end
                if (op == OP_MULW) begin
                    if (res_data[XLEN-1:XLEN/2] !== {(XLEN/2){res_data[XLEN/2-1]}}) begin
                        $display("[FAIL] %0t ns: MULW result 0x%h is not sign-extended",
                                 $time, res_data);
                        fail_count++;
                    end else begin
                        pass_count++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycles, exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int start_results;
        int start_accepted;
        int issued;
        seed      = 32'h93b55c7c;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_MUL;
        req_a     = '0;
        req_b     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        // All outputs come out of reset cleared
        if (busy !== 1'b0 || res_valid !== 1'b0 || res_data !== '0) begin
            $display("[FAIL] %0t ns: outputs not cleared by reset", $time);
            fail_count++;
        end else begin
            pass_count++;
        end
        for (int op = 0; op < 5; op++)
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    issue(op_from_index(op), corner_value(i), corner_value(j));
        end_test("Test 1 corner values");

        begin_test();
        for (int p = 0; p < 6; p++) begin
            logic [XLEN-1:0] a;
            logic [XLEN-1:0] b;
            case (p)
                0: {a, b} = {{XLEN{1'b1}}, {XLEN{1'b1}}};
                1: {a, b} = {{XLEN{1'b1}}, 64'd2};
                2: {a, b} = {corner_value(3), {XLEN{1'b1}}};
                3: {a, b} = {corner_value(4), {XLEN{1'b1}}};
                4: {a, b} = {64'h8000000000000001, 64'hfffffffffffffffe};
                default: {a, b} = {rand64(), rand64()};
            endcase
            issue(OP_MULH, a, b);
            issue(OP_MULHSU, a, b);
            issue(OP_MULHU, a, b);
        end
        end_test("Test 2 signedness");

        begin_test();
        issue(OP_MULW, 64'h000000007fffffff, 64'd2);  // Low word has bit 31 set
        issue(OP_MULW, 64'hffffffff00010000, 64'h8000);
        issue(OP_MULW, 64'd3, 64'd5);
        issue(OP_MULW, 64'h1234567887654321, 64'h0000000100000003);
        issue(OP_MULW, '1, '1);
        issue(OP_MULW, 64'h40000000, 64'd2);
        end_test("Test 3 MULW sign extension");

        begin_test();
        for (int n = 0; n < 200; n++)
            issue(op_from_index(rand_op_index()), rand64(), rand64());
        end_test("Test 4 random mix");

        // Hold req_valid with fresh operands every cycle, only idle cycles take one
        begin_test();
        start_results  = res_count;
        start_accepted = accepted;
        for (int c = 0; c < 40; c++) begin
            req_valid = 1'b1;
            req_op    = op_from_index(rand_op_index());
            req_a     = rand64();
            req_b     = rand64() & 64'hff;
            if (!busy) begin
                exp_q.push_back(ref_mul(req_op, req_a, req_b));
                op_q.push_back(req_op);
                accepted++;
            end
            @(negedge clk);
        end
        req_valid = 1'b0;
        drain();
        issued = accepted - start_accepted;
        if (res_count - start_results != issued) begin
            $display("[FAIL] %0t ns: %0d results for %0d accepted requests", $time,
                     res_count - start_results, issued);
            fail_count++;
        end else begin
            pass_count++;
        end
        end_test("Test 5 requests while busy");

        begin_test();
        for (int op = 0; op < 5; op++)
            issue(op_from_index(op), rand64() | 64'd1, '0);
        end_test("Test 6 zero multiplier");

        $display("Summary: %0d checks passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/mdu_pkg.sv
design/mul_req_if.sv
design/mul_rsp_if.sv
design/mul_operand_prep.sv
design/mul_shift_add.sv
design/mul_result_format.sv
design/mdu_top.sv
verif/mdu_chk.sv
verif/mdu_tb.sv

// ==== Makefile ====
TOP = mdu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir
